/* vlog.f */
+incdir+design
design/cryptoPkg.sv
design/ahbPkg.sv
design/ahbAddrPhase.sv
design/cryptoRegWrite.sv
design/jobFifo.sv
design/ahbCryptoWriteTop.sv
test/ahbCryptoWrite_assert.sv
test/tbAhbCryptoWrite.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbAhbCryptoWrite
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* test/tbAhbCryptoWrite.sv */
`timescale 1ns/1ps
`include "cryptoWrite_params.svh"

module tbAhbCryptoWrite
    import ahbPkg::*, cryptoPkg::*;
();

    localparam int NUM_TRANSFERS = 400;
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 5;
    localparam int HOLD_CYCLES   = 6;

    // One AHB transfer as the master sees it
    typedef struct packed {
        logic [31:0]               addr;
        logic                      write;
        htransType                 trans;
        hburstType                 burst;
        logic [`CW_DATA_WIDTH-1:0] data;
    } transferType;

    logic                      HCLK = 1'b0;
    logic                      HRESETn;
    logic                      HSEL;
    logic [31:0]               HADDR;
    logic                      HWRITE;
    htransType                 HTRANS;
    hburstType                 HBURST;
    logic [`CW_DATA_WIDTH-1:0] HWDATA;
    logic                      jobReady;
    logic                      HREADYOUT;
    logic                      HRESP;
    cryptoJobType              job;
    logic                      jobValid;

    integer                    seed;
    logic                      holdJobs;
    logic                      drainJobs;
    transferType               pending;
    // Reference copy of the key, nonce and destination registers
    cryptoJobType              modelRegs;
    cryptoJobType              expectedJobs[$];

    ahbCryptoWriteTop DUT (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HWRITE    (HWRITE),
        .HTRANS    (HTRANS),
        .HBURST    (HBURST),
        .HREADY    (HREADYOUT),
        .HWDATA    (HWDATA),
        .jobReady  (jobReady),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP),
        .job       (job),
        .jobValid  (jobValid)
    );

    always #(CLK_PERIOD / 2) HCLK = ~HCLK;

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compareResp(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            stopOnError($sformatf("MISMATCH at %0t: %s expected %0b, got %0b",
                                  $time, name, expected, actual));
    endtask

    task automatic compareJob(input cryptoJobType expected, input cryptoJobType actual);
        if (actual !== expected)
            stopOnError($sformatf("MISMATCH at %0t: job expected %h, got %h",
                                  $time, expected, actual));
    endtask

    task automatic compareWaits(input int expected, input int actual);
        if (actual != expected)
            stopOnError($sformatf("MISMATCH at %0t: HREADYOUT wait states expected %0d, got %0d",
                                  $time, expected, actual));
    endtask

    // NONSEQ and SEQ always count, BUSY only when it misuses a SINGLE burst
    function automatic logic isCommand(input transferType t);
        return (t.trans == NONSEQ) || (t.trans == SEQ)
            || ((t.trans == BUSY) && (t.burst == SINGLE));
    endfunction

    function automatic logic isError(input transferType t);
        logic mapped;
        mapped = (t.addr[11:0] == `CW_KEY_OFFSET) || (t.addr[11:0] == `CW_NONCE_OFFSET)
              || (t.addr[11:0] == `CW_DEST_OFFSET) || (t.addr[11:0] == `CW_TEXT_OFFSET);
        return !t.write || !mapped
            || ((t.burst == SINGLE) && ((t.trans == BUSY) || (t.trans == SEQ)));
    endfunction

    task automatic driveJobReady();
        if (holdJobs)
            jobReady = 1'b0;
        else if (drainJobs)
            jobReady = 1'b1;
        else
            jobReady = (($random(seed) & 3) == 0);
    endtask

    task automatic completeDataPhase(input logic resp, input int waits);
        cryptoJobType expJob;
        if (!isCommand(pending) || isError(pending))
        begin
            // ERROR only for a rejected command, OKAY when there was none
            compareResp("HRESP", isCommand(pending), resp);
            // The two-cycle ERROR response holds the bus for one wait state
            compareWaits(isCommand(pending) ? 1 : 0, waits);
        end
        else
        begin
            compareResp("HRESP", 1'b0, resp);
            // Only a text write can meet back-pressure from the job FIFO
            if (pending.addr[11:0] != `CW_TEXT_OFFSET)
                compareWaits(0, waits);
            case (pending.addr[11:0])
                `CW_KEY_OFFSET:   modelRegs.key = pending.data;
                `CW_NONCE_OFFSET: modelRegs.nonce = pending.data;
                `CW_DEST_OFFSET:  modelRegs.destination = pending.data;
                default:
                begin
                    expJob           = modelRegs;
                    expJob.plainText = pending.data;
                    expectedJobs.push_back(expJob);
                end
            endcase
        end
    endtask

    // Address phase of t overlaps the data phase of the pending transfer
    task automatic issue(input transferType t, output int waits);
        HADDR  = t.addr;
        HWRITE = t.write;
        HTRANS = t.trans;
        HBURST = t.burst;
        HWDATA = pending.data;
        waits  = 0;
        driveJobReady();
        @(negedge HCLK);
        while (!HREADYOUT)
        begin
            compareResp("HRESP", isCommand(pending) && isError(pending), HRESP);
            waits++;
            @(posedge HCLK);
            #1;
            driveJobReady();
            @(negedge HCLK);
        end
        completeDataPhase(HRESP, waits);
        pending = t;
        @(posedge HCLK);
        #1;
    endtask

    task automatic pickTransfer(input int beat, input logic burst, output transferType t);
        int          r;
        logic [11:0] offset;
        r       = $random(seed) & 15;
        t.burst = burst ? INCR : SINGLE;
        t.trans = (beat == 0) ? NONSEQ : SEQ;
        if (burst && (beat != 0) && (r == 0))
            t.trans = BUSY;
        else if (!burst && (r == 1))
            t.trans = SEQ;
        else if (!burst && (r == 4))
            t.trans = BUSY;
        else if (r == 2)
            t.trans = IDLE;
        t.write = (r != 3);
        case ($random(seed) & 7)
            0:       offset = `CW_KEY_OFFSET;
            1:       offset = `CW_NONCE_OFFSET;
            2:       offset = `CW_DEST_OFFSET;
            6:       offset = 12'($random(seed));
            default: offset = `CW_TEXT_OFFSET;
        endcase
        t.addr = {20'($random(seed)), offset};
        t.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic runRandomTraffic(input int count);
        transferType t;
        int          beats;
        int          waits;
        int          done;
        done = 0;
        while (done < count)
        begin
            // One beat is a SINGLE transfer, more make an INCR burst
            beats = ($random(seed) & 3) + 1;
            for (int b = 0; b < beats; b++)
            begin
                pickTransfer(b, beats > 1, t);
                issue(t, waits);
            end
            done += beats;
        end
    endtask

    task automatic drainQueue();
        drainJobs = 1'b1;
        driveJobReady();
        while (expectedJobs.size() != 0)
            @(negedge HCLK);
    endtask

    // Fill the FIFO with jobReady low, then one more text write must stall
    task automatic checkFullQueue();
        transferType t;
        int          waits;
        t = '0;
        issue(t, waits);
        drainQueue();
        holdJobs  = 1'b1;
        drainJobs = 1'b0;
        @(posedge HCLK);
        #1;
        t.addr  = {20'h0, `CW_TEXT_OFFSET};
        t.write = 1'b1;
        t.trans = NONSEQ;
        for (int i = 0; i <= `CW_FIFO_DEPTH; i++)
        begin
            t.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
            issue(t, waits);
            if (waits != 0)
                stopOnError("A text write stalled before the job FIFO was full");
        end
        t = '0;
        fork
            issue(t, waits);
            begin
                repeat (HOLD_CYCLES) @(negedge HCLK);
                holdJobs  = 1'b0;
                drainJobs = 1'b1;
            end
        join
        drainJobs = 1'b0;
        if (waits < HOLD_CYCLES)
            stopOnError("A text write completed while the job FIFO was full");
    endtask

    task automatic finishRun();
        transferType t;
        int          waits;
        t = '0;
        issue(t, waits);
        drainQueue();
        @(negedge HCLK);
        if (!jobValid && (expectedJobs.size() == 0))
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
            stopOnError("The job FIFO still holds jobs after all expected ones left");
    endtask

    // Job sink compares every handshake against the model queue
    always @(negedge HCLK)
    begin
        if (HRESETn && jobValid && jobReady)
        begin
            if (expectedJobs.size() == 0)
                stopOnError("A job left the FIFO with no text write behind it");
            else
                compareJob(expectedJobs.pop_front(), job);
        end
    end

    initial
    begin
        #(NUM_TRANSFERS * 40 * CLK_PERIOD);
        stopOnError("Timeout: the run did not finish within its time budget");
    end

    initial
    begin
        seed      = 25;
        HRESETn   = 1'b0;
        HSEL      = 1'b0;
        HADDR     = '0;
        HWRITE    = 1'b0;
        HTRANS    = IDLE;
        HBURST    = SINGLE;
        HWDATA    = '0;
        jobReady  = 1'b0;
        holdJobs  = 1'b0;
        drainJobs = 1'b0;
        pending   = '0;
        modelRegs = '0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;
        @(negedge HCLK);
        compareResp("HREADYOUT", 1'b1, HREADYOUT);
        compareResp("HRESP", 1'b0, HRESP);
        compareResp("jobValid", 1'b0, jobValid);
        @(posedge HCLK);
        #1;
        HSEL = 1'b1;
        runRandomTraffic(NUM_TRANSFERS / 2);
        checkFullQueue();
        runRandomTraffic(NUM_TRANSFERS / 2);
        finishRun();
    end

endmodule

/* test/ahbCryptoWrite_assert.sv */
`timescale 1ns/1ps

module ahbCryptoWriteAssert
    import cryptoPkg::*;
(
    input logic         HCLK,
    input logic         HRESETn,
    input logic         HREADYOUT,
    input logic         HRESP,
    input cryptoJobType job,
    input logic         jobValid,
    input logic         jobReady
);

    // First ERROR cycle is always followed by the closing one
    errorTwoCycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (HRESP && !HREADYOUT) |=> (HRESP && HREADYOUT))
        else $error("ERROR response did not close in its second cycle");

    // A stalled job must wait unchanged
    jobHeld: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (jobValid && !jobReady) |=> (jobValid && $stable(job)))
        else $error("Job output changed or vanished while jobReady was low");

    readyInReset: assert property (@(posedge HCLK) !HRESETn |-> HREADYOUT)
        else $error("HREADYOUT low during reset");

endmodule

bind ahbCryptoWriteTop ahbCryptoWriteAssert uAssert (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .job       (job),
    .jobValid  (jobValid),
    .jobReady  (jobReady)
);

/* design/ahbCryptoWriteTop.sv */
`timescale 1ns/1ps
`include "cryptoWrite_params.svh"

module ahbCryptoWriteTop
    import ahbPkg::*, cryptoPkg::*;
(
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  logic                      HSEL,
    input  logic [31:0]               HADDR,
    input  logic                      HWRITE,
    input  htransType                 HTRANS,
    input  hburstType                 HBURST,
    input  logic                      HREADY,
    input  logic [`CW_DATA_WIDTH-1:0] HWDATA,
    input  logic                      jobReady,
    output logic                      HREADYOUT,
    output logic                      HRESP,
    output cryptoJobType              job,
    output logic                      jobValid
);

    // Address phase to data phase
    addrCmdType   cmd;
    logic         cmdValid;
    logic         cmdReady;

    // Data phase to job queue
    cryptoJobType pushJob;
    logic         pushValid;
    logic         pushReady;

    ahbAddrPhase uAddrPhase (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .HSEL     (HSEL),
        .HADDR    (HADDR),
        .HWRITE   (HWRITE),
        .HTRANS   (HTRANS),
        .HBURST   (HBURST),
        .HREADY   (HREADY),
        .cmdReady (cmdReady),
        .cmd      (cmd),
        .cmdValid (cmdValid)
    );

    cryptoRegWrite uRegWrite (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .cmd       (cmd),
        .cmdValid  (cmdValid),
        .HWDATA    (HWDATA),
        .pushReady (pushReady),
        .cmdReady  (cmdReady),
        .HREADYOUT (HREADYOUT),
        .HRESP     (HRESP),
        .pushJob   (pushJob),
        .pushValid (pushValid)
    );

    jobFifo uJobFifo (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .pushJob   (pushJob),
        .pushValid (pushValid),
        .jobReady  (jobReady),
        .pushReady (pushReady),
        .job       (job),
        .jobValid  (jobValid)
    );

endmodule

/* design/jobFifo.sv */
`timescale 1ns/1ps
`include "cryptoWrite_params.svh"

module jobFifo
    import cryptoPkg::*;
(
    input  logic         HCLK,
    input  logic         HRESETn,
    input  cryptoJobType pushJob,
    input  logic         pushValid,
    input  logic         jobReady,
    output logic         pushReady,
    output cryptoJobType job,
    output logic         jobValid
);

    localparam int PTR_W = $clog2(`CW_FIFO_DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`CW_FIFO_DEPTH - 1);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(`CW_FIFO_DEPTH);

    cryptoJobType     mem [`CW_FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic             doPush;
    logic             doPop;

    assign jobValid  = (count != '0);
    assign job       = mem[rdPtr];
    // A pop in the same cycle frees a slot in a full buffer
    assign pushReady = (count != FULL_COUNT) || jobReady;
    assign doPush    = pushValid && pushReady;
    assign doPop     = jobValid && jobReady;

    always_ff @(posedge HCLK)
    begin
        if (doPush)
            mem[wrPtr] <= pushJob;
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
            if (doPush && !doPop)
                count <= count + 1'b1;
            else if (doPop && !doPush)
                count <= count - 1'b1;
        end
    end

endmodule

/* design/cryptoRegWrite.sv */
`timescale 1ns/1ps
`include "cryptoWrite_params.svh"

module cryptoRegWrite
    import ahbPkg::*, cryptoPkg::*;
(
    input  logic                      HCLK,
    input  logic                      HRESETn,
    input  addrCmdType                cmd,
    input  logic                      cmdValid,
    input  logic [`CW_DATA_WIDTH-1:0] HWDATA,
    input  logic                      pushReady,
    output logic                      cmdReady,
    output logic                      HREADYOUT,
    output logic                      HRESP,
    output cryptoJobType              pushJob,
    output logic                      pushValid
);

    // Second state only used for the closing cycle of an ERROR response
    typedef enum logic {
        DATA_FIRST,
        ERROR_LAST
    } dataStateType;

    dataStateType dataState;
    cryptoJobType regs;
    logic         writeDone;

    // Data phase response
    always_comb
    begin
        HREADYOUT = 1'b1;
        HRESP     = 1'b0;
        pushValid = 1'b0;
        if (cmdValid)
        begin
            if (cmd.errorFlag)
            begin
                HRESP     = 1'b1;
                HREADYOUT = (dataState == ERROR_LAST);
            end
            else if (cmd.textWrite)
            begin
                // Wait states until the queue has room
                pushValid = 1'b1;
                HREADYOUT = pushReady;
            end
        end
    end

    // Idle or in the last cycle of a data phase
    assign cmdReady  = HREADYOUT;
    assign writeDone = cmdValid && !cmd.errorFlag && HREADYOUT;

    // Job snapshot takes the incoming text, not the stored one
    always_comb
    begin
        pushJob           = regs;
        pushJob.plainText = HWDATA;
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            dataState <= DATA_FIRST;
        else if (cmdValid && cmd.errorFlag && (dataState == DATA_FIRST))
            dataState <= ERROR_LAST;
        else
            dataState <= DATA_FIRST;
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            regs <= '0;
        end
        else if (writeDone)
        begin
            case (cmd.target)
                KEY:     regs.key <= HWDATA;
                NONCE:   regs.nonce <= HWDATA;
                DEST:    regs.destination <= HWDATA;
                TEXT:    regs.plainText <= HWDATA;
                default: regs <= regs;
            endcase
        end
    end

endmodule

/* design/ahbAddrPhase.sv */
`timescale 1ns/1ps
`include "cryptoWrite_params.svh"

module ahbAddrPhase
    import ahbPkg::*, cryptoPkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL,
    input  logic [31:0] HADDR,
    input  logic        HWRITE,
    input  htransType   HTRANS,
    input  hburstType   HBURST,
    input  logic        HREADY,
    input  logic        cmdReady,
    output addrCmdType  cmd,
    output logic        cmdValid
);

    regTargetType target;
    logic         singleMisuse;
    logic         accept;
    addrCmdType   nextCmd;

    // Only the low 12 address bits select a register
    always_comb
    begin
        case (HADDR[11:0])
            `CW_KEY_OFFSET:   target = KEY;
            `CW_NONCE_OFFSET: target = NONCE;
            `CW_DEST_OFFSET:  target = DEST;
            `CW_TEXT_OFFSET:  target = TEXT;
            default:          target = NONE;
        endcase
    end

    // BUSY or SEQ make no sense without a burst
    assign singleMisuse = (HBURST == SINGLE) && ((HTRANS == BUSY) || (HTRANS == SEQ));

    // BUSY inside a real burst and IDLE are silently ignored
    assign accept = HSEL && HREADY
                 && ((HTRANS == NONSEQ) || (HTRANS == SEQ) || singleMisuse);

    always_comb
    begin
        nextCmd.target    = target;
        nextCmd.errorFlag = !HWRITE || singleMisuse || (target == NONE);
        nextCmd.textWrite = (target == TEXT) && !nextCmd.errorFlag;
    end

    // One-entry holding register, freed when the data phase ends
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            cmdValid <= 1'b0;
        else if (accept)
            cmdValid <= 1'b1;
        else if (cmdReady)
            cmdValid <= 1'b0;
    end

    always_ff @(posedge HCLK)
    begin
        if (accept)
            cmd <= nextCmd;
    end

endmodule

/* design/ahbPkg.sv */
package ahbPkg;

    import cryptoPkg::*;

    // HTRANS encodings
    typedef enum logic [1:0] {
        IDLE = 2'b00, BUSY = 2'b01, NONSEQ = 2'b10, SEQ = 2'b11
    } htransType;

    // HBURST encodings
    typedef enum logic [2:0] {
        SINGLE, INCR, WRAP4, INCR4, WRAP8, INCR8, WRAP16, INCR16
    } hburstType;

    // Decoded address phase handed to the data phase
    typedef struct packed {
        regTargetType target;
        logic         errorFlag;
        logic         textWrite;
    } addrCmdType;

endpackage

/* design/cryptoPkg.sv */
`include "cryptoWrite_params.svh"

package cryptoPkg;

    // Register addressed by an accepted transfer
    typedef enum logic [2:0] {
        KEY, NONCE, DEST, TEXT, NONE
    } regTargetType;

    // One encryption job as seen by the cipher core
    typedef struct packed {
        logic [`CW_DATA_WIDTH-1:0] key;
        logic [`CW_DATA_WIDTH-1:0] nonce;
        logic [`CW_DATA_WIDTH-1:0] destination;
        logic [`CW_DATA_WIDTH-1:0] plainText;
    } cryptoJobType;

endpackage

/* design/cryptoWrite_params.svh */
`ifndef CRYPTO_WRITE_PARAMS_SVH
`define CRYPTO_WRITE_PARAMS_SVH

// Width of the bus write data and of every accelerator register
`define CW_DATA_WIDTH 128

// Register offsets, compared on HADDR[11:0]
`define CW_KEY_OFFSET 12'h080

`define CW_NONCE_OFFSET 12'h100

`define CW_DEST_OFFSET 12'h180

`define CW_TEXT_OFFSET 12'h200

// Job queue entries
`define CW_FIFO_DEPTH 4

`endif
